/* source/cpuPkg.sv */
package cpuPkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int dataW = 16;
  localparam int regAddrW = 4;
  localparam int memDepth = 256;
  localparam int memAddrW = $clog2(memDepth);

  // Forwarding select encoding, memory stage wins over writeback
  localparam logic [1:0] fwdNone = 2'd0;
  localparam logic [1:0] fwdMem = 2'd1;
  localparam logic [1:0] fwdWb = 2'd2;

  //////////////////////////////
  // ISA encodings
  //////////////////////////////

  typedef enum logic [3:0] {
    opAdd = 4'b0000,
    opSub = 4'b0001,
    opAnd = 4'b0010,
    opOr  = 4'b0011,
    opSll = 4'b0100,
    opSrl = 4'b0101,
    opLw  = 4'b1000,
    opSw  = 4'b1001,
    opLlb = 4'b1010,
    opB   = 4'b1100,
    opHlt = 4'b1111
  } opcodeT;

  // Branch condition, instruction bits [11:9]
  typedef enum logic [2:0] {
    condNe = 3'b000,
    condEq = 3'b001,
    condGt = 3'b010,
    condLt = 3'b011,
    condGe = 3'b100,
    condLe = 3'b101,
    condOv = 3'b110,
    condUn = 3'b111
  } condT;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////

  // All-zero payload is a bubble in every stage
  typedef struct packed {
    logic valid;
    logic [dataW-1:0] pcPlus2;
    logic [dataW-1:0] instr;
  } ifIdT;

  typedef struct packed {
    opcodeT op;
    condT cond;
    logic [dataW-1:0] rsData;
    logic [dataW-1:0] rtData;
    logic [regAddrW-1:0] rsIdx;
    logic [regAddrW-1:0] rtIdx;
    logic [regAddrW-1:0] rd;
    logic [dataW-1:0] imm;
    logic [dataW-1:0] pcPlus2;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic isBranch;
    logic isHalt;
  } idExT;

  typedef struct packed {
    logic [dataW-1:0] result;
    logic [dataW-1:0] storeData;
    logic [regAddrW-1:0] rd;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic isHalt;
  } exMemT;

  typedef struct packed {
    logic [dataW-1:0] wbData;
    logic [regAddrW-1:0] rd;
    logic regWrite;
    logic isHalt;
  } memWbT;

  // Flag write enables as {z, v, n}
  function automatic logic [2:0] flagWrite(opcodeT op);
    case (op)
      opAdd, opSub: return 3'b111;
      opAnd, opOr, opSll, opSrl: return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

endpackage

/* source/pipeReg.sv */
`timescale 1ns/100ps

// Stage register shared by all four pipeline boundaries
module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic clk,
  input  logic arstN,
  input  logic stall,
  input  logic flush,
  input  payloadT d,
  output payloadT q
);

  // Flush beats stall, both give way to reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (flush) begin
      // Zero payload acts as a bubble
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

/* source/fetchStage.sv */
`timescale 1ns/100ps

module fetchStage import cpuPkg::*; (
  input  logic clk,
  input  logic arstN,
  input  logic run,
  input  logic stall,
  input  logic fetchHold,
  input  logic branchTaken,
  input  logic [dataW-1:0] branchTarget,
  input  logic progWe,
  input  logic [memAddrW-1:0] progAddr,
  input  logic [dataW-1:0] progData,
  output logic [dataW-1:0] pc,
  output ifIdT ifOut
);

  // Instruction memory, word addressed
  logic [dataW-1:0] instrMem [memDepth];
  logic [dataW-1:0] pcPlus2;

  assign pcPlus2 = pc + dataW'(2);

  //////////////////////////////
  // Program counter
  //////////////////////////////

  // Idle core parks at 0, then branch, hold, sequential
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!run) begin
      pc <= '0;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else if (!(stall || fetchHold)) begin
      pc <= pcPlus2;
    end
  end

  // Load port, only used while idle
  always_ff @(posedge clk) begin
    if (progWe) begin
      instrMem[progAddr] <= progData;
    end
  end

  // Combinational fetch, bubble when idle or halting
  always_comb begin
    ifOut = '0;
    if (run && !fetchHold) begin
      ifOut.valid = 1'b1;
      ifOut.pcPlus2 = pcPlus2;
      ifOut.instr = instrMem[pc[memAddrW:1]];
    end
  end

  // Loading a running program would corrupt fetch
  progWhileIdle: assert property (@(posedge clk) disable iff (!arstN) progWe |-> !run)
    else $error("progWe high while run is high");

endmodule

/* source/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage import cpuPkg::*; (
  input  logic clk,
  input  logic arstN,
  input  ifIdT ifIn,
  input  logic wbWe,
  input  logic [regAddrW-1:0] wbReg,
  input  logic [dataW-1:0] wbData,
  output idExT idOut,
  output logic [regAddrW-1:0] rsIdx,
  output logic [regAddrW-1:0] rtIdx,
  output logic rsUsed,
  output logic rtUsed,
  output logic isHaltId
);

  logic [dataW-1:0] regFile [2**regAddrW];
  logic [dataW-1:0] instr;
  opcodeT op;
  logic [regAddrW-1:0] rdIdx;
  logic isAlu;

  //////////////////////////////
  // Field split
  //////////////////////////////

  assign instr = ifIn.instr;
  assign op = opcodeT'(instr[15:12]);
  assign rdIdx = instr[11:8];
  assign rsIdx = instr[7:4];
  // Store data comes from the rd field, routed on the rt port
  assign rtIdx = (op == opSw) ? rdIdx : instr[3:0];

  // Register-register and shift group
  assign isAlu = (op == opAdd) || (op == opSub) || (op == opAnd) || (op == opOr) ||
                 (op == opSll) || (op == opSrl);

  // Source usage, feeds stall and forwarding
  assign rsUsed = ifIn.valid && (isAlu || op == opLw || op == opSw);
  assign rtUsed = ifIn.valid &&
                  (op == opAdd || op == opSub || op == opAnd || op == opOr || op == opSw);
  assign isHaltId = ifIn.valid && (op == opHlt);

  //////////////////////////////
  // Register file
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 2**regAddrW; i++) begin
        regFile[i] <= '0;
      end
    end else if (wbWe) begin
      regFile[wbReg] <= wbData;
    end
  end

  // Control and payload build
  always_comb begin
    idOut = '0;
    idOut.op = op;
    idOut.cond = condT'(instr[11:9]);
    idOut.rsIdx = rsIdx;
    idOut.rtIdx = rtIdx;
    idOut.rd = rdIdx;
    idOut.pcPlus2 = ifIn.pcPlus2;
    // Write-through so a retiring value is seen this cycle
    idOut.rsData = (wbWe && wbReg == rsIdx) ? wbData : regFile[rsIdx];
    idOut.rtData = (wbWe && wbReg == rtIdx) ? wbData : regFile[rtIdx];
    case (op)
      opLlb: idOut.imm = {{(dataW-8){instr[7]}}, instr[7:0]};
      opLw, opSw: idOut.imm = {{(dataW-4){instr[3]}}, instr[3:0]};
      opSll, opSrl: idOut.imm = {{(dataW-4){1'b0}}, instr[3:0]};
      // Branch offset in words
      opB: idOut.imm = {{(dataW-9){instr[8]}}, instr[8:0]};
      default: idOut.imm = '0;
    endcase
    // Unknown opcodes and bubbles fall through as no-ops
    idOut.regWrite = ifIn.valid && (isAlu || op == opLlb || op == opLw);
    idOut.memRead = ifIn.valid && (op == opLw);
    idOut.memToReg = ifIn.valid && (op == opLw);
    idOut.memWrite = ifIn.valid && (op == opSw);
    idOut.isBranch = ifIn.valid && (op == opB);
    idOut.isHalt = isHaltId;
  end

endmodule

/* source/execStage.sv */
`timescale 1ns/100ps

module execStage import cpuPkg::*; (
  input  logic clk,
  input  logic arstN,
  input  idExT exIn,
  input  logic [1:0] fwdSelA,
  input  logic [1:0] fwdSelB,
  input  logic [dataW-1:0] memFwdData,
  input  logic [dataW-1:0] wbFwdData,
  output exMemT exOut,
  output logic branchTaken,
  output logic [dataW-1:0] branchTarget
);

  logic [dataW-1:0] opA;
  logic [dataW-1:0] opB;
  logic [dataW-1:0] aluRes;
  logic ovfl;
  logic zFlag, vFlag, nFlag;
  logic [2:0] flagEn;
  logic condMet;

  //////////////////////////////
  // Operand forwarding
  //////////////////////////////

  always_comb begin
    case (fwdSelA)
      fwdMem: opA = memFwdData;
      fwdWb: opA = wbFwdData;
      default: opA = exIn.rsData;
    endcase
    case (fwdSelB)
      fwdMem: opB = memFwdData;
      fwdWb: opB = wbFwdData;
      default: opB = exIn.rtData;
    endcase
  end

  // ALU
  always_comb begin
    aluRes = '0;
    ovfl = 1'b0;
    case (exIn.op)
      opAdd: begin
        aluRes = opA + opB;
        // Same signs in, other sign out
        ovfl = (opA[dataW-1] == opB[dataW-1]) && (aluRes[dataW-1] != opA[dataW-1]);
      end
      opSub: begin
        aluRes = opA - opB;
        ovfl = (opA[dataW-1] != opB[dataW-1]) && (aluRes[dataW-1] != opA[dataW-1]);
      end
      opAnd: aluRes = opA & opB;
      opOr: aluRes = opA | opB;
      opSll: aluRes = opA << exIn.imm[3:0];
      opSrl: aluRes = opA >> exIn.imm[3:0];
      opLlb: aluRes = exIn.imm;
      // Effective address
      opLw, opSw: aluRes = opA + exIn.imm;
      default: aluRes = '0;
    endcase
  end

  //////////////////////////////
  // Flags
  //////////////////////////////

  // Bubbles carry regWrite low and leave flags alone
  assign flagEn = exIn.regWrite ? flagWrite(exIn.op) : 3'b000;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      zFlag <= 1'b0;
      vFlag <= 1'b0;
      nFlag <= 1'b0;
    end else begin
      if (flagEn[2]) zFlag <= (aluRes == '0);
      if (flagEn[1]) vFlag <= ovfl;
      if (flagEn[0]) nFlag <= aluRes[dataW-1];
    end
  end

  // Branch against flags of older instructions
  always_comb begin
    case (exIn.cond)
      condNe: condMet = !zFlag;
      condEq: condMet = zFlag;
      condGt: condMet = !zFlag && !nFlag;
      condLt: condMet = nFlag;
      condGe: condMet = !nFlag;
      condLe: condMet = zFlag || nFlag;
      condOv: condMet = vFlag;
      default: condMet = 1'b1;
    endcase
  end

  assign branchTaken = exIn.isBranch && condMet;
  assign branchTarget = exIn.pcPlus2 + {exIn.imm[dataW-2:0], 1'b0};

  // Payload to memory stage
  always_comb begin
    exOut = '0;
    exOut.result = aluRes;
    exOut.storeData = opB;
    exOut.rd = exIn.rd;
    exOut.memRead = exIn.memRead;
    exOut.memWrite = exIn.memWrite;
    exOut.memToReg = exIn.memToReg;
    exOut.regWrite = exIn.regWrite;
    exOut.isHalt = exIn.isHalt;
  end

  // Memory stage holds last cycle's exOut
  memFwdA: assert property (@(posedge clk) disable iff (!arstN)
    fwdSelA == fwdMem |-> $past(exOut.regWrite) && $past(exOut.rd) == exIn.rsIdx)
    else $error("fwdSelA picks memory stage without a matching write");
  memFwdB: assert property (@(posedge clk) disable iff (!arstN)
    fwdSelB == fwdMem |-> $past(exOut.regWrite) && $past(exOut.rd) == exIn.rtIdx)
    else $error("fwdSelB picks memory stage without a matching write");

endmodule

/* source/memStage.sv */
`timescale 1ns/100ps

module memStage import cpuPkg::*; (
  input  logic clk,
  input  exMemT memIn,
  output memWbT memOut
);

  // Data memory, contents undefined until stored
  logic [dataW-1:0] dataMem [memDepth];
  logic [dataW-1:0] loadData;
  logic [memAddrW-1:0] wordAddr;

  // Byte address to word index
  assign wordAddr = memIn.result[memAddrW:1];

  always_ff @(posedge clk) begin
    if (memIn.memWrite) begin
      dataMem[wordAddr] <= memIn.storeData;
    end
  end

  // Combinational read
  assign loadData = dataMem[wordAddr];

  always_comb begin
    memOut = '0;
    memOut.wbData = memIn.memToReg ? loadData : memIn.result;
    memOut.rd = memIn.rd;
    memOut.regWrite = memIn.regWrite;
    memOut.isHalt = memIn.isHalt;
  end

endmodule

/* source/hazardCtrl.sv */
`timescale 1ns/100ps

module hazardCtrl import cpuPkg::*; (
  input  logic clk,
  input  logic arstN,
  input  logic run,
  input  logic [regAddrW-1:0] rsIdx,
  input  logic [regAddrW-1:0] rtIdx,
  input  logic rsUsed,
  input  logic rtUsed,
  input  logic [regAddrW-1:0] exRd,
  input  logic exRegWrite,
  input  logic exMemRead,
  input  logic [regAddrW-1:0] memRd,
  input  logic memRegWrite,
  input  logic memMemRead,
  input  logic branchTaken,
  input  logic isHaltId,
  input  logic isHaltWb,
  output logic [1:0] fwdSelA,
  output logic [1:0] fwdSelB,
  output logic stall,
  output logic bubble,
  output logic flush,
  output logic fetchHold,
  output logic hlt
);

  logic loadUse;
  logic haltSeen;
  logic hltQ;
  logic [1:0] selA, selB;

  // Load in execute feeding the instruction in decode
  assign loadUse = exMemRead && ((rsUsed && exRd == rsIdx) || (rtUsed && exRd == rtIdx));
  assign stall = run && loadUse;
  assign bubble = stall;
  // Idle core keeps the front stages empty
  assign flush = branchTaken || !run;

  //////////////////////////////
  // Forwarding
  //////////////////////////////

  // Decode looks one stage ahead so selects land with the instruction
  always_comb begin
    selA = fwdNone;
    selB = fwdNone;
    if (rsUsed && exRegWrite && exRd == rsIdx) selA = fwdMem;
    else if (rsUsed && memRegWrite && memRd == rsIdx) selA = fwdWb;
    if (rtUsed && exRegWrite && exRd == rtIdx) selB = fwdMem;
    else if (rtUsed && memRegWrite && memRd == rtIdx) selB = fwdWb;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fwdSelA <= fwdNone;
      fwdSelB <= fwdNone;
    end else if (flush || bubble) begin
      fwdSelA <= fwdNone;
      fwdSelB <= fwdNone;
    end else begin
      fwdSelA <= selA;
      fwdSelB <= selB;
    end
  end

  //////////////////////////////
  // Halt tracking
  //////////////////////////////

  // HLT under a taken branch gets flushed and sets no hold
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltSeen <= 1'b0;
      hltQ <= 1'b0;
    end else begin
      if (isHaltId && !branchTaken) haltSeen <= 1'b1;
      if (isHaltWb) hltQ <= 1'b1;
    end
  end

  assign fetchHold = haltSeen || (isHaltId && !branchTaken);
  assign hlt = hltQ || isHaltWb;

  // Bubble behind the load clears the hazard on the next cycle
  stallOnce: assert property (@(posedge clk) disable iff (!arstN) stall |=> !stall)
    else $error("load-use stall held for more than one cycle");
  // Load results only ever reach execute from writeback
  noLoadFwd: assert property (@(posedge clk) disable iff (!arstN)
    (fwdSelA == fwdMem || fwdSelB == fwdMem) |-> !memMemRead)
    else $error("memory stage load forwarded before data is read");

endmodule

/* source/cpu.sv */
`timescale 1ns/100ps

module cpu import cpuPkg::*; (
  input  logic clk,
  input  logic arstN,
  input  logic run,
  input  logic progWe,
  input  logic [memAddrW-1:0] progAddr,
  input  logic [dataW-1:0] progData,
  output logic [dataW-1:0] pc,
  output logic hlt,
  output logic wbValid,
  output logic [regAddrW-1:0] wbReg,
  output logic [dataW-1:0] wbData
);

  ifIdT ifOut, ifIdQ;
  idExT idOut, idExQ;
  exMemT exOut, exMemQ;
  memWbT memOut, memWbQ;

  logic [regAddrW-1:0] rsIdx, rtIdx;
  logic rsUsed, rtUsed, isHaltId;
  logic [1:0] fwdSelA, fwdSelB;
  logic stall, bubble, flush, fetchHold;
  logic branchTaken;
  logic [dataW-1:0] branchTarget;

  //////////////////////////////
  // Fetch and decode
  //////////////////////////////

  fetchStage i_fetch (
    .clk(clk), .arstN(arstN), .run(run), .stall(stall), .fetchHold(fetchHold),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .pc(pc), .ifOut(ifOut)
  );

  pipeReg #(.payloadT(ifIdT)) i_ifIdReg (
    .clk(clk), .arstN(arstN), .stall(stall), .flush(flush), .d(ifOut), .q(ifIdQ)
  );

  // Writeback drives the register file write port
  decodeStage i_decode (
    .clk(clk), .arstN(arstN), .ifIn(ifIdQ),
    .wbWe(wbValid), .wbReg(wbReg), .wbData(wbData),
    .idOut(idOut), .rsIdx(rsIdx), .rtIdx(rtIdx),
    .rsUsed(rsUsed), .rtUsed(rtUsed), .isHaltId(isHaltId)
  );

  // Load-use bubble enters here
  pipeReg #(.payloadT(idExT)) i_idExReg (
    .clk(clk), .arstN(arstN), .stall(1'b0), .flush(flush || bubble), .d(idOut), .q(idExQ)
  );

  //////////////////////////////
  // Execute, memory, writeback
  //////////////////////////////

  execStage i_exec (
    .clk(clk), .arstN(arstN), .exIn(idExQ), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
    .memFwdData(exMemQ.result), .wbFwdData(memWbQ.wbData),
    .exOut(exOut), .branchTaken(branchTaken), .branchTarget(branchTarget)
  );

  pipeReg #(.payloadT(exMemT)) i_exMemReg (
    .clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(exOut), .q(exMemQ)
  );

  memStage i_mem (.clk(clk), .memIn(exMemQ), .memOut(memOut));

  pipeReg #(.payloadT(memWbT)) i_memWbReg (
    .clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(memOut), .q(memWbQ)
  );

  // Retire port
  assign wbValid = memWbQ.regWrite;
  assign wbReg = memWbQ.rd;
  assign wbData = memWbQ.wbData;

  hazardCtrl i_hazard (
    .clk(clk), .arstN(arstN), .run(run),
    .rsIdx(rsIdx), .rtIdx(rtIdx), .rsUsed(rsUsed), .rtUsed(rtUsed),
    .exRd(idExQ.rd), .exRegWrite(idExQ.regWrite), .exMemRead(idExQ.memRead),
    .memRd(exMemQ.rd), .memRegWrite(exMemQ.regWrite), .memMemRead(exMemQ.memRead),
    .branchTaken(branchTaken), .isHaltId(isHaltId), .isHaltWb(memWbQ.isHalt),
    .fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .stall(stall), .bubble(bubble),
    .flush(flush), .fetchHold(fetchHold), .hlt(hlt)
  );

endmodule

/* sim/cpuTb.sv */
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

  localparam int numTests = 6;
  localparam int progLen = 64;
  localparam int cyclesPerInstr = 40;
  // Load and store base that the random body never writes
  localparam logic [3:0] baseReg = 4'd15;

  logic clk;
  logic arstN;
  logic run;
  logic progWe;
  logic [memAddrW-1:0] progAddr;
  logic [dataW-1:0] progData;
  logic [dataW-1:0] pc;
  logic hlt;
  logic wbValid;
  logic [regAddrW-1:0] wbReg;
  logic [dataW-1:0] wbData;

  integer seed;
  int errors;
  int passedTests;
  int progCnt;
  logic [15:0] prog [progLen];
  logic [3:0] prevRd1;
  logic [3:0] prevRd2;
  logic [3:0] expReg [$];
  logic [15:0] expData [$];
  logic [3:0] gotReg [$];
  logic [15:0] gotData [$];

  cpu i_dut (
    .clk(clk), .arstN(arstN), .run(run),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .pc(pc), .hlt(hlt), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  always #5 clk = ~clk;

  // Budget scales with total program length
  initial begin
    #(numTests * progLen * cyclesPerInstr * 10);
    $display("Watchdog expired after %0d cycles, core never halted",
             numTests * progLen * cyclesPerInstr);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  //////////////////////////////
  // Program generator
  //////////////////////////////

  function automatic int rnd(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [3:0] aluOp();
    case (rnd(6))
      0: return opAdd;
      1: return opSub;
      2: return opAnd;
      3: return opOr;
      4: return opSll;
      default: return opSrl;
    endcase
  endfunction

  // Last slot is kept for HLT
  task automatic emit(logic [15:0] word);
    if (progCnt < progLen - 1) begin
      prog[progCnt] = word;
      progCnt++;
    end
  endtask

  task automatic emitAlu(logic [3:0] rd, logic [3:0] rs, logic [3:0] rt);
    emit({aluOp(), rd, rs, rt});
    prevRd2 = prevRd1;
    prevRd1 = rd;
  endtask

  task automatic emitLlb(logic [3:0] rd);
    emit({opLlb, rd, 8'(rnd(256))});
    prevRd2 = prevRd1;
    prevRd1 = rd;
  endtask

  // Kinds 1 to 4 focus one hazard class and higher kinds mix them
  task automatic genStep(int kind);
    int k;
    int maxOff;
    int off;
    logic [3:0] rd;
    logic [3:0] src;
    logic [3:0] imm;
    k = kind;
    if (kind > 4) k = 1 + rnd(4);
    rd = 4'(rnd(15));
    imm = 4'(rnd(16));
    case (k)
      1: begin
        if (rnd(5) == 0) emitLlb(rd);
        else emitAlu(rd, 4'(rnd(16)), 4'(rnd(16)));
      end
      2: begin
        // Source at distance one or two
        src = (rnd(2) == 0) ? prevRd1 : prevRd2;
        if (rnd(2) == 0) emitAlu(rd, src, 4'(rnd(16)));
        else emitAlu(rd, 4'(rnd(16)), src);
      end
      3: begin
        case (rnd(4))
          0: begin
            // Load then immediate consumer
            emit({opLw, rd, baseReg, imm});
            emitAlu(4'(rnd(15)), rd, 4'(rnd(16)));
          end
          1: begin
            emit({opLw, rd, baseReg, imm});
            emit({opSw, rd, baseReg, 4'(rnd(16))});
          end
          2: begin
            // Store then load of the same word
            emit({opSw, 4'(rnd(16)), baseReg, imm});
            emit({opLw, rd, baseReg, imm});
          end
          default: emitAlu(rd, 4'(rnd(16)), 4'(rnd(16)));
        endcase
      end
      default: begin
        // Flag setter or LLB right before the branch
        if (rnd(3) == 0) emitLlb(rd);
        else emitAlu(rd, 4'(rnd(16)), 4'(rnd(16)));
        maxOff = progLen - 2 - progCnt;
        off = rnd(4);
        if (off > maxOff) off = maxOff;
        if (off < 0) off = 0;
        emit({opB, 3'(rnd(8)), 9'(off)});
      end
    endcase
  endtask

  task automatic genProgram(int kind);
    progCnt = 0;
    prevRd1 = '0;
    prevRd2 = '0;
    // Reset test reads flags and registers before any seed
    if (kind == 6) begin
      emit({opB, 3'(rnd(8)), 9'd1});
      emit({opOr, 4'd1, 4'(rnd(16)), 4'(rnd(16))});
      emit({opAdd, 4'd2, 4'(rnd(16)), 4'(rnd(16))});
    end
    // Seed every register with the base at 0x40
    for (int r = 0; r < 15; r++) begin
      emit({opLlb, 4'(r), 8'(rnd(256))});
    end
    emit({opLlb, baseReg, 8'h40});
    // Fill every data word the body can reach
    for (int o = -8; o < 8; o += 2) begin
      emit({opSw, 4'(rnd(16)), baseReg, 4'(o)});
    end
    while (progCnt < progLen - 1) begin
      genStep(kind);
    end
    prog[progLen-1] = {opHlt, 12'h000};
  endtask

  //////////////////////////////
  // ISA model
  //////////////////////////////

  // Runs one instruction at a time and records every register write
  task automatic runModel();
    logic [15:0] r [16];
    logic [15:0] dmem [256];
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] ea;
    logic z;
    logic v;
    logic n;
    logic taken;
    logic wr;
    logic done;
    int idx;
    int steps;
    int full;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    z = 0;
    v = 0;
    n = 0;
    done = 0;
    idx = 0;
    steps = 0;
    expReg.delete();
    expData.delete();
    while (!done && steps < 4 * progLen) begin
      w = prog[idx];
      a = r[w[7:4]];
      b = r[w[3:0]];
      ea = a + {{12{w[3]}}, w[3:0]};
      res = '0;
      wr = 0;
      idx++;
      steps++;
      case (w[15:12])
        opAdd, opSub: begin
          // Signed overflow from the full-width result
          if (w[15:12] == opAdd) full = int'($signed(a)) + int'($signed(b));
          else full = int'($signed(a)) - int'($signed(b));
          res = 16'(full);
          v = (full > 32767) || (full < -32768);
          n = res[15];
          z = (res == 0);
          wr = 1;
        end
        opAnd, opOr, opSll, opSrl: begin
          if (w[15:12] == opAnd) res = a & b;
          else if (w[15:12] == opOr) res = a | b;
          else if (w[15:12] == opSll) res = a << w[3:0];
          else res = a >> w[3:0];
          z = (res == 0);
          wr = 1;
        end
        opLlb: begin
          res = {{8{w[7]}}, w[7:0]};
          wr = 1;
        end
        opLw: begin
          res = dmem[ea[8:1]];
          wr = 1;
        end
        opSw: dmem[ea[8:1]] = r[w[11:8]];
        opB: begin
          case (w[11:9])
            condNe: taken = !z;
            condEq: taken = z;
            condGt: taken = !z && !n;
            condLt: taken = n;
            condGe: taken = !n;
            condLe: taken = z || n;
            condOv: taken = v;
            default: taken = 1;
          endcase
          if (taken) idx = idx + int'($signed(w[8:0]));
        end
        opHlt: done = 1;
        default: ;
      endcase
      if (wr) begin
        r[w[11:8]] = res;
        expReg.push_back(w[11:8]);
        expData.push_back(res);
      end
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  task automatic runTest(int t);
    string name;
    int startErrors;
    logic [15:0] hltPc;
    case (t)
      1: name = "alu";
      2: name = "forward";
      3: name = "memory";
      4: name = "branch";
      5: name = "halt";
      default: name = "reset";
    endcase
    startErrors = errors;
    genProgram(t);
    runModel();
    gotReg.delete();
    gotData.delete();
    // Fresh reset for every program
    @(posedge clk);
    #1;
    arstN = 0;
    run = 0;
    progWe = 0;
    repeat (10) @(posedge clk);
    #1 arstN = 1;
    for (int i = 0; i < progLen; i++) begin
      progWe = 1;
      progAddr = memAddrW'(i);
      progData = prog[i];
      @(posedge clk);
      #1;
    end
    progWe = 0;
    run = 1;
    // Outputs settle by the falling edge
    @(negedge clk);
    while (!hlt) begin
      if (wbValid) begin
        gotReg.push_back(wbReg);
        gotData.push_back(wbData);
      end
      @(negedge clk);
    end
    checkEq("wbValid", wbValid, 0);
    checkEq("writeback count", gotReg.size(), expReg.size());
    for (int k = 0; k < expReg.size() && k < gotReg.size(); k++) begin
      checkEq($sformatf("wbReg[%0d]", k), gotReg[k], expReg[k]);
      checkEq($sformatf("wbData[%0d]", k), gotData[k], expData[k]);
    end
    // Halted core stays quiet
    hltPc = pc;
    repeat (8) begin
      @(negedge clk);
      checkEq("wbValid", wbValid, 0);
      checkEq("pc", pc, hltPc);
      checkEq("hlt", hlt, 1);
    end
    if (errors == startErrors) passedTests++;
    $display("Test %0d %s: %0d writebacks, %0d errors, %s", t, name, gotReg.size(),
             errors - startErrors, (errors == startErrors) ? "passed" : "failed");
  endtask

  initial begin
    clk = 0;
    arstN = 0;
    run = 0;
    progWe = 0;
    progAddr = '0;
    progData = '0;
    errors = 0;
    passedTests = 0;
    seed = 32'hce8b1074;
    for (int t = 1; t <= numTests; t++) begin
      runTest(t);
    end
    $display("%0d of %0d tests passed, %0d errors", passedTests, numTests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
source/cpuPkg.sv
source/pipeReg.sv
source/fetchStage.sv
source/decodeStage.sv
source/execStage.sv
source/memStage.sv
source/hazardCtrl.sv
source/cpu.sv
sim/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpu testbench with Verilator, result from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuTb -f project.f -o cpuTbSim \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/cpuTbSim > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && exit 0 || exit 1
